// File: rv_lite_pkg.sv
package rv_lite_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    localparam word_t pc_step = 32'd4;  // Sequential fetch increment

    // Opcodes of the kept subset
    localparam logic [6:0] opc_r      = 7'b0110011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // Function codes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;  // lw and sw
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_sub     = 7'b0100000;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;    // imm[11:5]
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;    // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One fetched word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
    } instr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_sll
    } alu_op_t;

    typedef enum logic [1:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_j
    } imm_sel_t;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_link
    } result_sel_t;

    typedef struct packed {
        logic        reg_we;
        logic        mem_we;
        logic        alu_use_imm;
        logic        is_branch;
        logic        is_jump;
        alu_op_t     alu_op;
        result_sel_t result_sel;
    } ctrl_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage

// File: fetch_stage.sv
module fetch_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               take_target,  // jal, or beq taken
    input  rv_lite_pkg::word_t imm,
    output rv_lite_pkg::word_t pc,
    output rv_lite_pkg::word_t pc_plus4
);
    import rv_lite_pkg::*;

    word_t target;
    word_t pc_next;

    // Both candidates are formed every cycle, wrap is modulo 2^32
    always_comb begin
        pc_plus4 = pc + pc_step;
        target   = pc + imm;
    end

    assign pc_next = take_target ? target : pc_plus4;

    ////////////////////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;  // One instruction per cycle
        end
    end

endmodule

// File: decode_stage.sv
module decode_stage (
    input  rv_lite_pkg::instr_t   instr,
    output rv_lite_pkg::ctrl_t    ctrl,
    output rv_lite_pkg::word_t    imm,
    output rv_lite_pkg::reg_idx_t rs1,
    output rv_lite_pkg::reg_idx_t rs2,
    output rv_lite_pkg::reg_idx_t rd
);
    import rv_lite_pkg::*;

    imm_sel_t   imm_sel;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Register and function fields sit at the same spot in every format
    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;

    ////////////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl    = '0;     // Everything off, acts as a no-op
        imm_sel = imm_i;

        case (opcode)
            opc_r: begin
                case ({funct7, funct3})
                    {f7_base, f3_add_sub}: begin
                        ctrl.reg_we = 1'b1;
                        ctrl.alu_op = alu_add;
                    end
                    {f7_sub, f3_add_sub}: begin
                        ctrl.reg_we = 1'b1;
                        ctrl.alu_op = alu_sub;
                    end
                    {f7_base, f3_and}: begin
                        ctrl.reg_we = 1'b1;
                        ctrl.alu_op = alu_and;
                    end
                    {f7_base, f3_or}: begin
                        ctrl.reg_we = 1'b1;
                        ctrl.alu_op = alu_or;
                    end
                    {f7_base, f3_sll}: begin
                        ctrl.reg_we = 1'b1;
                        ctrl.alu_op = alu_sll;
                    end
                    default: ;
                endcase
            end
            opc_imm: begin
                if (funct3 == f3_add_sub) begin  // addi only
                    ctrl.reg_we      = 1'b1;
                    ctrl.alu_use_imm = 1'b1;
                end
            end
            opc_load: begin
                if (funct3 == f3_word) begin
                    ctrl.reg_we      = 1'b1;
                    ctrl.alu_use_imm = 1'b1;
                    ctrl.result_sel  = res_mem;
                end
            end
            opc_store: begin
                if (funct3 == f3_word) begin
                    ctrl.mem_we      = 1'b1;
                    ctrl.alu_use_imm = 1'b1;
                    imm_sel          = imm_s;
                end
            end
            opc_branch: begin
                if (funct3 == f3_beq) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.alu_op    = alu_sub;  // Equal when the difference is zero
                    imm_sel        = imm_b;
                end
            end
            opc_jal: begin
                ctrl.reg_we     = 1'b1;
                ctrl.is_jump    = 1'b1;
                ctrl.result_sel = res_link;
                imm_sel         = imm_j;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Immediate extension
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (imm_sel)
            imm_s:   imm = {{(xlen-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            imm_b:   imm = {{(xlen-13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                            instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            imm_j:   imm = {{(xlen-21){instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                            instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            default: imm = {{(xlen-12){instr.i.imm[11]}}, instr.i.imm};
        endcase
    end

endmodule

// File: reg_file.sv
module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  rv_lite_pkg::reg_idx_t rs1,
    input  rv_lite_pkg::reg_idx_t rs2,
    input  rv_lite_pkg::reg_idx_t rd,
    input  rv_lite_pkg::word_t    wdata,
    output rv_lite_pkg::word_t    rdata1,
    output rv_lite_pkg::word_t    rdata2
);
    import rv_lite_pkg::*;

    word_t regs [num_regs];

    // Asynchronous reads, x0 forced to zero
    always_comb begin
        rdata1 = (rs1 == '0) ? '0 : regs[rs1];
        rdata2 = (rs2 == '0) ? '0 : regs[rs2];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 never written
            regs[rd] <= wdata;
        end
    end

endmodule

// File: execute_stage.sv
module execute_stage (
    input  rv_lite_pkg::ctrl_t ctrl,
    input  rv_lite_pkg::word_t rdata1,
    input  rv_lite_pkg::word_t rdata2,
    input  rv_lite_pkg::word_t imm,
    output rv_lite_pkg::word_t alu_result,
    output logic               take_target
);
    import rv_lite_pkg::*;

    localparam int shamt_w = $clog2(xlen);

    word_t op_b;
    logic  zero;

    assign op_b = ctrl.alu_use_imm ? imm : rdata2;  // addi, lw, sw use the immediate

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.alu_op)
            alu_add: alu_result = rdata1 + op_b;
            alu_sub: alu_result = rdata1 - op_b;
            alu_and: alu_result = rdata1 & op_b;
            alu_or:  alu_result = rdata1 | op_b;
            alu_sll: alu_result = rdata1 << op_b[shamt_w-1:0];  // Low five bits only
            default: alu_result = '0;
        endcase
    end

    assign zero = (alu_result == '0);

    // Redirect for jal, or for beq with equal operands
    assign take_target = ctrl.is_jump | (ctrl.is_branch & zero);

endmodule

// File: mem_wb_stage.sv
module mem_wb_stage (
    input  rv_lite_pkg::ctrl_t     ctrl,
    input  rv_lite_pkg::word_t     alu_result,
    input  rv_lite_pkg::word_t     rdata2,
    input  rv_lite_pkg::word_t     pc_plus4,
    input  rv_lite_pkg::word_t     dmem_rdata,
    output rv_lite_pkg::dmem_req_t dmem_req,
    output rv_lite_pkg::word_t     wb_data
);
    import rv_lite_pkg::*;

    // Store request, address from base plus offset
    always_comb begin
        dmem_req.we    = ctrl.mem_we;
        dmem_req.addr  = alu_result;
        dmem_req.wdata = rdata2;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write-back select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.result_sel)
            res_mem:  wb_data = dmem_rdata;  // lw
            res_link: wb_data = pc_plus4;    // jal return address
            default:  wb_data = alu_result;
        endcase
    end

endmodule

// File: rv_lite_core.sv
module rv_lite_core (
    input  logic                   clk,
    input  logic                   rst_n,
    output rv_lite_pkg::word_t     imem_addr,
    input  rv_lite_pkg::instr_t    imem_instr,
    output rv_lite_pkg::dmem_req_t dmem_req,
    input  rv_lite_pkg::word_t     dmem_rdata
);
    import rv_lite_pkg::*;

    ctrl_t    ctrl;
    word_t    imm;
    word_t    pc_plus4;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rdata1;
    word_t    rdata2;
    word_t    alu_result;
    word_t    wb_data;
    logic     take_target;

    ////////////////////////////////////////////////////////////////////////////
    // Stages, all within one cycle
    ////////////////////////////////////////////////////////////////////////////

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .take_target (take_target),
        .imm         (imm),
        .pc          (imem_addr),  // pc goes straight to instruction memory
        .pc_plus4    (pc_plus4)
    );

    decode_stage u_decode (
        .instr (imem_instr),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (ctrl.reg_we),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execute_stage u_execute (
        .ctrl        (ctrl),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .imm         (imm),
        .alu_result  (alu_result),
        .take_target (take_target)
    );

    mem_wb_stage u_mem_wb (
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .rdata2     (rdata2),
        .pc_plus4   (pc_plus4),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .wb_data    (wb_data)
    );

endmodule

// File: rv_lite_tb.sv
module rv_lite_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_lite_pkg::*;

    localparam int reset_cycles = 3;
    localparam int max_steps    = 64;
    localparam int trace_cols   = 6;
    localparam int slack_cycles = 20;

    // One cycle of the trace
    typedef struct packed {
        instr_t instr;
        word_t  rdata;
        word_t  pc;
        logic   we;
        word_t  addr;
        word_t  wdata;
    } step_t;

    logic      clk = 1'b0;
    logic      rst_n;
    instr_t    imem_instr;
    word_t     dmem_rdata;
    word_t     imem_addr;
    dmem_req_t dmem_req;

    word_t trace_mem [1 + max_steps*trace_cols];  // Step count, then six words per step
    int    num_steps;
    int    cur_step       = -1;                   // -1 while in reset
    int    cycle_count    = 0;
    int    timeout_cycles = max_steps + reset_cycles + slack_cycles;
    step_t step;

    rv_lite_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_instr (imem_instr),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    always #2 clk = ~clk;  // 4 ns period

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Fail %s at step %0d: got 0x%h, expected 0x%h",
                     name, cur_step, actual, expected);
            abort_run();
        end
    endtask

    function automatic step_t trace_step(input int k);
        step_t s;
        int    base;
        base    = 1 + k*trace_cols;
        s.instr = trace_mem[base];
        s.rdata = trace_mem[base+1];
        s.pc    = trace_mem[base+2];
        s.we    = trace_mem[base+3][0];
        s.addr  = trace_mem[base+4];
        s.wdata = trace_mem[base+5];
        return s;
    endfunction

    // Run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout after %0d cycles, the trace playback never finished",
                     cycle_count);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reset and trace playback
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n      = 1'b0;
        imem_instr = '0;  // Unsupported opcode, so no store during reset
        dmem_rdata = '0;

        $readmemh("rv_lite_trace.txt", trace_mem);
        num_steps = trace_mem[0];
        if (num_steps < 1 || num_steps > max_steps) begin
            $display("The trace file holds an invalid step count of %0d", num_steps);
            abort_run();
        end
        timeout_cycles = num_steps + reset_cycles + slack_cycles;

        // Each reset cycle is checked after its rising edge
        for (int c = 0; c < reset_cycles; c++) begin
            @(posedge clk);
            #1;
            check_value("imem_addr", imem_addr, '0);
            check_value("dmem_req.we", word_t'(dmem_req.we), '0);
        end
        @(negedge clk);
        rst_n = 1'b1;

        for (int k = 0; k < num_steps; k++) begin
            cur_step   = k;
            step       = trace_step(k);
            imem_instr = step.instr;
            dmem_rdata = step.rdata;
            #1;  // Sample 1 ns before the rising edge
            check_value("imem_addr", imem_addr, step.pc);
            check_value("dmem_req.we", word_t'(dmem_req.we), word_t'(step.we));
            if (step.we) begin
                check_value("dmem_req.addr", dmem_req.addr, step.addr);
                check_value("dmem_req.wdata", dmem_req.wdata, step.wdata);
            end
            @(negedge clk);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: rv_lite_trace.txt
// Each line holds instr, load data, expected pc, expected we, store address, store data
// Store address and data are only checked on lines where we is 1
00000024                                            // number of cycle lines
10000093 00000000 00000000 0 00000000 00000000  // addi x1, x0, 256
01900113 00000000 00000004 0 00000000 00000000  // addi x2, x0, 25
ff400193 00000000 00000008 0 00000000 00000000  // addi x3, x0, -12
00310233 00000000 0000000c 0 00000000 00000000  // add x4, x2, x3
403102b3 00000000 00000010 0 00000000 00000000  // sub x5, x2, x3
00317333 00000000 00000014 0 00000000 00000000  // and x6, x2, x3
003163b3 00000000 00000018 0 00000000 00000000  // or x7, x2, x3
02300493 00000000 0000001c 0 00000000 00000000  // addi x9, x0, 35
00911433 00000000 00000020 0 00000000 00000000  // sll x8, x2, x9
0040a023 00000000 00000024 1 00000100 0000000d  // sw x4, 0(x1)
0050a223 00000000 00000028 1 00000104 00000025  // sw x5, 4(x1)
0060a423 00000000 0000002c 1 00000108 00000010  // sw x6, 8(x1)
0070a623 00000000 00000030 1 0000010c fffffffd  // sw x7, 12(x1)
0080a823 00000000 00000034 1 00000110 000000c8  // sw x8, 16(x1)
fe30ae23 00000000 00000038 1 000000fc fffffff4  // sw x3, -4(x1)
0200a503 cafe1234 0000003c 0 00000000 00000000  // lw x10, 32(x1)
00a0aa23 00000000 00000040 1 00000114 cafe1234  // sw x10, 20(x1)
00910463 00000000 00000044 0 00000000 00000000  // beq x2, x9, +8 not taken
00420663 00000000 00000048 0 00000000 00000000  // beq x4, x4, +12 taken
010005ef 00000000 00000054 0 00000000 00000000  // jal x11, +16
00b0ac23 00000000 00000064 1 00000118 00000058  // sw x11, 24(x1)
00200613 00000000 00000068 0 00000000 00000000  // addi x12, x0, 2
fff60613 00000000 0000006c 0 00000000 00000000  // addi x12, x12, -1
00060463 00000000 00000070 0 00000000 00000000  // beq x12, x0, +8 not taken
fe000ce3 00000000 00000074 0 00000000 00000000  // beq x0, x0, -8 taken
fff60613 00000000 0000006c 0 00000000 00000000  // addi x12, x12, -1
00060463 00000000 00000070 0 00000000 00000000  // beq x12, x0, +8 taken
05500013 5a5a5a5a 00000078 0 00000000 00000000  // addi x0, x0, 0x55
00210033 00000000 0000007c 0 00000000 00000000  // add x0, x2, x2
0000ae23 00000000 00000080 1 0000011c 00000000  // sw x0, 28(x1)
ffffffff 00000000 00000084 0 00000000 00000000  // unsupported opcode
40217233 00000000 00000088 0 00000000 00000000  // bad funct7 with and, rd x4
00208023 00000000 0000008c 0 00000000 00000000  // sb is outside the subset
0240a223 00000000 00000090 1 00000124 0000000d  // sw x4, 36(x1)
f6dff06f 00000000 00000094 0 00000000 00000000  // jal x0, -148
00000000 00000000 00000000 0 00000000 00000000  // back at zero

// File: rv_lite.f
rv_lite_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_wb_stage.sv
rv_lite_core.sv
rv_lite_tb.sv

// File: Bender.yml
package:
  name: rv_lite

sources:
  - rv_lite_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - reg_file.sv
  - execute_stage.sv
  - mem_wb_stage.sv
  - rv_lite_core.sv
  - target: simulation
    files:
      - rv_lite_tb.sv
